// ==== common/afu_ctl_macros.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AFU control block register map and field widths
// Word offsets on the 5-bit Wishbone address and the widths
// of the packed request fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef AFU_CTL_MACROS_SVH
`define AFU_CTL_MACROS_SVH

// CSR word offsets
`define AFU_CSR_DSM_BASEL       5'd0
`define AFU_CSR_DSM_BASEH       5'd1
`define AFU_CSR_CNTXT_BASEL     5'd2
`define AFU_CSR_CNTXT_BASEH     5'd3
`define AFU_CSR_AFU_EN          5'd4
`define AFU_CSR_TRIGGER_DEBUG   5'd5
`define AFU_CSR_ENABLE_TEST     5'd6
`define AFU_CSR_SREG_READ       5'd7
`define AFU_CSR_READ_FRAME_L    5'd8
`define AFU_CSR_READ_FRAME_H    5'd9
`define AFU_CSR_WRITE_FRAME_L   5'd10
`define AFU_CSR_WRITE_FRAME_H   5'd11
`define AFU_CSR_SREG_RSP        5'd12

// Field widths
`define AFU_SREG_ADDR_W         4
`define AFU_TEST_LEN_W          12
`define AFU_DBG_IDX_W           4
`define AFU_DBG_SUB_W           8

`endif

// ==== common/afu_ctl_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AFU control block types
// CSR state broadcast, request and response structs and the
// address-dependent view of one written word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "afu_ctl_macros.svh"

package afu_ctl_pkg;

    // A nonzero index is a request, the sub-index selects within it
    typedef struct packed {
        logic [`AFU_DBG_SUB_W-1:0] sub_idx;
        logic [`AFU_DBG_IDX_W-1:0] idx;
    } afu_dbg_req_t;

    // Start sits directly above the length field
    typedef struct packed {
        logic                       start;
        logic [`AFU_TEST_LEN_W-1:0] len;
    } afu_test_req_t;

    typedef struct packed {
        logic                        enable;
        logic [`AFU_SREG_ADDR_W-1:0] addr;
    } afu_sreg_req_t;

    // State seen by every consumer of the CSR block
    typedef struct packed {
        logic [63:0]   dsm_base;
        logic          dsm_base_valid;
        logic [63:0]   cntxt_base;
        logic          cntxt_base_valid;
        logic          afu_en;
        logic          afu_en_user_channel;
        afu_dbg_req_t  dbg;
        afu_test_req_t test;
        afu_sreg_req_t sreg;
        logic [63:0]   read_frame;
        logic [63:0]   write_frame;
    } afu_csr_state_t;

    // One write word, read according to the register it targets
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [29:0] rsvd;
            logic        user_channel;
            logic        en;
        } en_v;
        struct packed {
            logic [31-`AFU_DBG_SUB_W-`AFU_DBG_IDX_W:0] rsvd;
            afu_dbg_req_t                              dbg;
        } dbg_v;
        struct packed {
            logic [30-`AFU_TEST_LEN_W:0] rsvd;
            afu_test_req_t               test;
        } test_v;
        struct packed {
            logic [31-`AFU_SREG_ADDR_W:0] rsvd;
            logic [`AFU_SREG_ADDR_W-1:0]  addr;
        } sreg_v;
    } afu_csr_wdata_u;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } afu_sreg_rsp_t;

endpackage

// ==== src/afu_ctl/afu_csr_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AFU CSR decode stage
// Wishbone classic slave that turns host writes into the
// broadcast CSR state and answers register reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "afu_ctl_macros.svh"

module afu_csr_decode import afu_ctl_pkg::*; (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           wb_cyc,
    input  logic           wb_stb,
    input  logic           wb_we,
    input  logic [4:0]     wb_adr,
    input  afu_csr_wdata_u wb_dat_w,
    output logic [31:0]    wb_dat_r,
    output logic           wb_ack,
    input  afu_sreg_rsp_t  sreg_rsp,
    output afu_csr_state_t csr
);

    logic        xfer_accept;
    logic        wr_en;
    logic        rd_en;
    logic [31:0] rd_word;

    // A transfer is taken once, in the cycle before ack rises
    assign xfer_accept = wb_cyc & wb_stb & ~wb_ack;
    assign wr_en       = xfer_accept & wb_we;
    assign rd_en       = xfer_accept & ~wb_we;

    // Ack is high for exactly one cycle per transfer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= xfer_accept;
        end
    end

    // Registers load on the same edge that raises ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr <= '0;
        end else begin
            // Request pulses drop after one cycle, sub-index and sreg address stay
            csr.dbg.idx     <= '0;
            csr.test.start  <= 1'b0;
            csr.sreg.enable <= 1'b0;
            if (wr_en) begin
                case (wb_adr)
                    `AFU_CSR_DSM_BASEL: begin
                        csr.dsm_base[31:0] <= wb_dat_w.raw;
                        csr.dsm_base_valid <= 1'b1;
                    end
                    `AFU_CSR_DSM_BASEH:     csr.dsm_base[63:32] <= wb_dat_w.raw;
                    `AFU_CSR_CNTXT_BASEL: begin
                        csr.cntxt_base[31:0] <= wb_dat_w.raw;
                        csr.cntxt_base_valid <= 1'b1;
                    end
                    `AFU_CSR_CNTXT_BASEH:   csr.cntxt_base[63:32] <= wb_dat_w.raw;
                    `AFU_CSR_AFU_EN: begin
                        csr.afu_en              <= wb_dat_w.en_v.en;
                        csr.afu_en_user_channel <= wb_dat_w.en_v.user_channel;
                    end
                    `AFU_CSR_TRIGGER_DEBUG: csr.dbg <= wb_dat_w.dbg_v.dbg;
                    `AFU_CSR_ENABLE_TEST:   csr.test <= wb_dat_w.test_v.test;
                    `AFU_CSR_SREG_READ: begin
                        csr.sreg.enable <= 1'b1;
                        csr.sreg.addr   <= wb_dat_w.sreg_v.addr;
                    end
                    `AFU_CSR_READ_FRAME_L:  csr.read_frame[31:0] <= wb_dat_w.raw;
                    `AFU_CSR_READ_FRAME_H:  csr.read_frame[63:32] <= wb_dat_w.raw;
                    `AFU_CSR_WRITE_FRAME_L: csr.write_frame[31:0] <= wb_dat_w.raw;
                    `AFU_CSR_WRITE_FRAME_H: csr.write_frame[63:32] <= wb_dat_w.raw;
                    default: ;
                endcase
            end
        end
    end

    // Readback of the stored fields, pulse bits always read as 0
    always_comb begin
        rd_word = '0;
        case (wb_adr)
            `AFU_CSR_DSM_BASEL:     rd_word = csr.dsm_base[31:0];
            `AFU_CSR_DSM_BASEH:     rd_word = csr.dsm_base[63:32];
            `AFU_CSR_CNTXT_BASEL:   rd_word = csr.cntxt_base[31:0];
            `AFU_CSR_CNTXT_BASEH:   rd_word = csr.cntxt_base[63:32];
            `AFU_CSR_AFU_EN:        rd_word = {30'd0, csr.afu_en_user_channel, csr.afu_en};
            `AFU_CSR_TRIGGER_DEBUG: rd_word = {20'd0, csr.dbg.sub_idx, 4'd0};
            `AFU_CSR_ENABLE_TEST:   rd_word = {19'd0, 1'b0, csr.test.len};
            `AFU_CSR_SREG_READ:     rd_word = {28'd0, csr.sreg.addr};
            `AFU_CSR_READ_FRAME_L:  rd_word = csr.read_frame[31:0];
            `AFU_CSR_READ_FRAME_H:  rd_word = csr.read_frame[63:32];
            `AFU_CSR_WRITE_FRAME_L: rd_word = csr.write_frame[31:0];
            `AFU_CSR_WRITE_FRAME_H: rd_word = csr.write_frame[63:32];
            // The status word reads as 0 until the first response is latched
            `AFU_CSR_SREG_RSP:      rd_word = sreg_rsp.valid ? sreg_rsp.data : 32'd0;
            default:                rd_word = '0;
        endcase
    end

    // Read data is captured at accept and presented alongside ack
    always_ff @(posedge clk) begin
        if (rd_en) begin
            wb_dat_r <= rd_word;
        end
    end

endmodule

// ==== src/afu_ctl/afu_test_exec.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AFU execute stage
// Enabled-cycle counter, timed self-test with a completion
// count, and the last debug sub-index
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "afu_ctl_macros.svh"

module afu_test_exec import afu_ctl_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  afu_csr_state_t            csr,
    output logic [31:0]               cycle_count,
    output logic [15:0]               tests_done,
    output logic                      test_busy,
    output logic [`AFU_DBG_SUB_W-1:0] dbg_sub
);

    // Cycles still to run after the current one
    logic [`AFU_TEST_LEN_W-1:0] test_remain;

    // Free-running while the AFU is enabled, frozen otherwise
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle_count <= '0;
        end else if (csr.afu_en) begin
            cycle_count <= cycle_count + 32'd1;
        end
    end

    // Self-test timer
    // A start with length L keeps busy high for L+1 cycles
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            test_busy   <= 1'b0;
            test_remain <= '0;
            tests_done  <= '0;
        end else if (test_busy) begin
            if (test_remain == '0) begin
                // Last busy cycle, the run is counted as it ends
                test_busy  <= 1'b0;
                tests_done <= tests_done + 16'd1;
            end else begin
                test_remain <= test_remain - 1'b1;
            end
        end else if (csr.test.start) begin
            // Starts that arrive while busy never reach this branch
            test_busy   <= 1'b1;
            test_remain <= csr.test.len;
        end
    end

    // Only a real debug request updates the stored sub-index
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dbg_sub <= '0;
        end else if (csr.dbg.idx != '0) begin
            dbg_sub <= csr.dbg.sub_idx;
        end
    end

endmodule

// ==== src/afu_ctl/afu_sreg_result.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AFU status register result stage
// Selects one status word per read request and holds it for
// the host to read back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "afu_ctl_macros.svh"

module afu_sreg_result import afu_ctl_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  afu_csr_state_t            csr,
    input  logic [31:0]               cycle_count,
    input  logic [15:0]               tests_done,
    input  logic                      test_busy,
    input  logic [`AFU_DBG_SUB_W-1:0] dbg_sub,
    output afu_sreg_rsp_t             sreg_rsp
);

    logic [31:0] sel_word;

    // Status map indexed by the held sreg address
    always_comb begin
        case (csr.sreg.addr)
            4'd0:    sel_word = csr.dsm_base[31:0];
            4'd1:    sel_word = csr.dsm_base[63:32];
            4'd2:    sel_word = csr.cntxt_base[31:0];
            4'd3:    sel_word = csr.cntxt_base[63:32];
            4'd4:    sel_word = {30'd0, csr.cntxt_base_valid, csr.dsm_base_valid};
            4'd5:    sel_word = cycle_count;
            4'd6:    sel_word = {test_busy, 15'd0, tests_done};
            4'd7:    sel_word = {{(32-`AFU_DBG_SUB_W){1'b0}}, dbg_sub};
            default: sel_word = '0;
        endcase
    end

    // The word is latched one cycle after the request pulse
    // Valid marks that a response has been captured since reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sreg_rsp <= '0;
        end else if (csr.sreg.enable) begin
            sreg_rsp.valid <= 1'b1;
            sreg_rsp.data  <= sel_word;
        end
    end

endmodule

// ==== src/afu_ctl_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AFU control block top level
// Wishbone CSR decode feeding the execute and status stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module afu_ctl_top import afu_ctl_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [4:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        afu_en,
    output logic        test_busy
);

    afu_csr_state_t csr;
    afu_sreg_rsp_t  sreg_rsp;

    // Status bundle from execute to result
    logic [31:0] cycle_count;
    logic [15:0] tests_done;
    logic [7:0]  dbg_sub;

    afu_csr_decode afu_csr_decode_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .sreg_rsp (sreg_rsp),
        .csr      (csr)
    );

    afu_test_exec afu_test_exec_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .csr         (csr),
        .cycle_count (cycle_count),
        .tests_done  (tests_done),
        .test_busy   (test_busy),
        .dbg_sub     (dbg_sub)
    );

    afu_sreg_result afu_sreg_result_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .csr         (csr),
        .cycle_count (cycle_count),
        .tests_done  (tests_done),
        .test_busy   (test_busy),
        .dbg_sub     (dbg_sub),
        .sreg_rsp    (sreg_rsp)
    );

    assign afu_en = csr.afu_en;

endmodule

// ==== dv/afu_ctl_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AFU control block testbench
// Table-driven Wishbone transfers checked against a model of
// the register map, with a watchdog and a per-test report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "afu_ctl_macros.svh"

module afu_ctl_tb;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_RDM, OP_RDGT, OP_RDEQ, OP_IDLE, OP_PORT} op_e;

    // Reads compare against exp, against the model (RDM) or against the previous read
    typedef struct packed {
        logic [3:0]  test;
        op_e         op;
        logic [4:0]  addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic [31:0] mask;
    } entry_t;

    logic        clk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [4:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        afu_en;
    logic        test_busy;

    entry_t      tbl[$];
    logic [31:0] lfsr = 32'h1c5;
    logic        built = 1'b0;
    int          cyc_n = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_checks = 0;
    int          test_errors = 0;
    logic [31:0] last_rd;

    // Register map model fed by the writes the table issues
    logic [31:0] m_reg [0:31];
    logic        m_dsm_v;
    logic        m_ctx_v;
    logic [7:0]  m_dbg_sub;
    int          m_started;
    int          m_busy_end;
    logic [3:0]  m_sreg_idx;
    int          m_sreg_n;
    logic        m_sreg_v;

    afu_ctl_top afu_ctl_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .afu_en    (afu_en),
        .test_busy (test_busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Edge count used to time the self-test in the model
    always @(posedge clk) cyc_n <= cyc_n + 1;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int width);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < width; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // Busy runs from the edge after acceptance n up to edge n+L+2
    function automatic void model_write(input logic [4:0] addr, input logic [31:0] data,
                                        input int n);
        m_reg[addr] = data;
        case (addr)
            `AFU_CSR_DSM_BASEL:   m_dsm_v = 1'b1;
            `AFU_CSR_CNTXT_BASEL: m_ctx_v = 1'b1;
            `AFU_CSR_TRIGGER_DEBUG: begin
                if (data[3:0] != 4'd0) begin
                    m_dbg_sub = data[11:4];
                end
            end
            `AFU_CSR_ENABLE_TEST: begin
                // A start accepted before the running test ends is dropped
                if (data[12] && n >= m_busy_end) begin
                    m_started++;
                    m_busy_end = n + int'(data[11:0]) + 2;
                end
            end
            `AFU_CSR_SREG_READ: begin
                m_sreg_v   = 1'b1;
                m_sreg_idx = data[3:0];
                m_sreg_n   = n;
            end
            default: ;
        endcase
    endfunction

    // Status word as seen one edge after the SREG_READ write
    function automatic logic [31:0] sreg_expect();
        logic        busy;
        logic [15:0] done;
        busy = (m_sreg_n < m_busy_end);
        done = 16'(m_started - (busy ? 1 : 0));
        if (!m_sreg_v) begin
            return 32'd0;
        end
        case (m_sreg_idx)
            4'd0:    return m_reg[`AFU_CSR_DSM_BASEL];
            4'd1:    return m_reg[`AFU_CSR_DSM_BASEH];
            4'd2:    return m_reg[`AFU_CSR_CNTXT_BASEL];
            4'd3:    return m_reg[`AFU_CSR_CNTXT_BASEH];
            4'd4:    return {30'd0, m_ctx_v, m_dsm_v};
            4'd6:    return {busy, 15'd0, done};
            4'd7:    return {24'd0, m_dbg_sub};
            default: return 32'd0;
        endcase
    endfunction

    task automatic add(input int test, input op_e op, input logic [4:0] addr,
                       input logic [31:0] data, input logic [31:0] exp, input logic [31:0] mask);
        entry_t e;
        e.test = 4'(test);
        e.op   = op;
        e.addr = addr;
        e.data = data;
        e.exp  = exp;
        e.mask = mask;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] sub;
        // Test 1 covers the state after reset
        // Before any SREG_READ the response reads 0
        add(1, OP_RDM, `AFU_CSR_SREG_RSP, 0, 0, '1);
        add(1, OP_WR, `AFU_CSR_SREG_READ, 32'd4, 0, 0);
        add(1, OP_RDM, `AFU_CSR_SREG_RSP, 0, 0, '1);
        add(1, OP_WR, `AFU_CSR_SREG_READ, 32'd6, 0, 0);
        add(1, OP_RDM, `AFU_CSR_SREG_RSP, 0, 0, '1);
        add(1, OP_PORT, 0, 0, 32'd0, 32'd3);
        // Base halves sit at offsets 0 to 3 and at sreg indices 0 to 3
        for (int a = 0; a < 4; a++) begin
            add(2, OP_WR, 5'(a), rand_bits(32), 0, 0);
            add(2, OP_RDM, 5'(a), 0, 0, '1);
            add(2, OP_WR, `AFU_CSR_SREG_READ, 32'(a), 0, 0);
            add(2, OP_RDM, `AFU_CSR_SREG_RSP, 0, 0, '1);
            add(2, OP_WR, `AFU_CSR_SREG_READ, 32'd4, 0, 0);
            add(2, OP_RDM, `AFU_CSR_SREG_RSP, 0, 0, '1);
        end
        // Enabled cycle counter grows and then freezes
        add(3, OP_WR, `AFU_CSR_AFU_EN, 32'd1, 0, 0);
        add(3, OP_PORT, 0, 0, 32'd1, 32'd1);
        add(3, OP_WR, `AFU_CSR_SREG_READ, 32'd5, 0, 0);
        add(3, OP_RD, `AFU_CSR_SREG_RSP, 0, 0, 0);
        add(3, OP_IDLE, 0, 32'd5, 0, 0);
        add(3, OP_WR, `AFU_CSR_SREG_READ, 32'd5, 0, 0);
        add(3, OP_RDGT, `AFU_CSR_SREG_RSP, 0, 0, 0);
        add(3, OP_WR, `AFU_CSR_AFU_EN, 32'd0, 0, 0);
        add(3, OP_PORT, 0, 0, 32'd0, 32'd1);
        add(3, OP_WR, `AFU_CSR_SREG_READ, 32'd5, 0, 0);
        add(3, OP_RD, `AFU_CSR_SREG_RSP, 0, 0, 0);
        add(3, OP_IDLE, 0, 32'd5, 0, 0);
        add(3, OP_WR, `AFU_CSR_SREG_READ, 32'd5, 0, 0);
        add(3, OP_RDEQ, `AFU_CSR_SREG_RSP, 0, 0, 0);
        // Self-test of length 20 with a second start while busy
        add(4, OP_WR, `AFU_CSR_ENABLE_TEST, 32'h0000_1014, 0, 0);
        add(4, OP_PORT, 0, 0, 32'd2, 32'd2);
        add(4, OP_WR, `AFU_CSR_ENABLE_TEST, 32'h0000_1014, 0, 0);
        add(4, OP_WR, `AFU_CSR_SREG_READ, 32'd6, 0, 0);
        add(4, OP_RDM, `AFU_CSR_SREG_RSP, 0, 0, '1);
        add(4, OP_IDLE, 0, 32'd30, 0, 0);
        add(4, OP_PORT, 0, 0, 32'd0, 32'd2);
        add(4, OP_WR, `AFU_CSR_SREG_READ, 32'd6, 0, 0);
        add(4, OP_RDM, `AFU_CSR_SREG_RSP, 0, 0, '1);
        // Debug sub-index stored for index 3 and kept for index 0
        sub = rand_bits(8);
        add(5, OP_WR, `AFU_CSR_TRIGGER_DEBUG, {20'd0, sub[7:0], 4'd3}, 0, 0);
        add(5, OP_WR, `AFU_CSR_SREG_READ, 32'd7, 0, 0);
        add(5, OP_RDM, `AFU_CSR_SREG_RSP, 0, 0, '1);
        sub = rand_bits(8);
        add(5, OP_WR, `AFU_CSR_TRIGGER_DEBUG, {20'd0, sub[7:0], 4'd0}, 0, 0);
        add(5, OP_WR, `AFU_CSR_SREG_READ, 32'd7, 0, 0);
        add(5, OP_RDM, `AFU_CSR_SREG_RSP, 0, 0, '1);
        // Frame words followed by an unmapped offset and an unmapped sreg index
        for (int a = 8; a < 12; a++) begin
            add(6, OP_WR, 5'(a), rand_bits(32), 0, 0);
            add(6, OP_RDM, 5'(a), 0, 0, '1);
        end
        add(6, OP_RD, 5'd20, 0, 32'd0, '1);
        add(6, OP_WR, `AFU_CSR_SREG_READ, 32'd12, 0, 0);
        add(6, OP_RD, `AFU_CSR_SREG_RSP, 0, 32'd0, '1);
    endtask

    function automatic void count_check();
        checks++;
        test_checks++;
    endfunction

    function automatic void count_error();
        errors++;
        test_errors++;
    endfunction

    // Starts 2 ns after an edge and returns 2 ns after the ack edge
    task automatic bus_xfer(input logic we, input logic [4:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output int n);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_w = data;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_ack && waited < 8);
        if (!wb_ack) begin
            count_error();
            $display("transfer to address 0x%h was never acknowledged", addr);
        end
        rdata = wb_dat_r;
        n     = cyc_n;
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic apply_entry(input entry_t e);
        logic [31:0] rd;
        logic [31:0] expv;
        int          n;
        case (e.op)
            OP_WR: begin
                bus_xfer(1'b1, e.addr, e.data, rd, n);
                model_write(e.addr, e.data, n);
            end
            OP_IDLE: repeat (e.data) @(posedge clk);
            OP_PORT: begin
                if (e.mask[0]) begin
                    count_check();
                    if (afu_en !== e.exp[0]) begin
                        count_error();
                        $display("error: afu_en expected 0x%h actual 0x%h", e.exp[0], afu_en);
                    end
                end
                if (e.mask[1]) begin
                    count_check();
                    if (test_busy !== e.exp[1]) begin
                        count_error();
                        $display("error: test_busy expected 0x%h actual 0x%h",
                                 e.exp[1], test_busy);
                    end
                end
            end
            default: begin
                bus_xfer(1'b0, e.addr, 32'd0, rd, n);
                // A read with an empty mask only takes a snapshot for the next compare
                if (e.op != OP_RD || e.mask != '0) begin
                    count_check();
                end
                expv = e.exp;
                if (e.op == OP_RDM) begin
                    expv = (e.addr == `AFU_CSR_SREG_RSP) ? sreg_expect() : m_reg[e.addr];
                end
                if (e.op == OP_RDGT && !(rd > last_rd)) begin
                    count_error();
                    $display("error: cycle_count 0x%h is not above 0x%h", rd, last_rd);
                end
                if (e.op == OP_RDEQ && rd !== last_rd) begin
                    count_error();
                    $display("error: cycle_count expected 0x%h actual 0x%h", last_rd, rd);
                end
                if ((e.op == OP_RD || e.op == OP_RDM) && (rd & e.mask) !== (expv & e.mask)) begin
                    count_error();
                    $display("error: wb_dat_r at 0x%h expected 0x%h actual 0x%h",
                             e.addr, expv & e.mask, rd & e.mask);
                end
                last_rd = rd;
            end
        endcase
    endtask

    task automatic report_test(input logic [3:0] test);
        $display("test %0d finished: %0d checks, %0d errors", test, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        arst_n   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        last_rd  = '0;
        for (int i = 0; i < 32; i++) begin
            m_reg[i] = '0;
        end
        m_dsm_v    = 1'b0;
        m_ctx_v    = 1'b0;
        m_dbg_sub  = '0;
        m_started  = 0;
        m_busy_end = 0;
        m_sreg_idx = '0;
        m_sreg_n   = 0;
        m_sreg_v   = 1'b0;
        build_table();
        built = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;
        foreach (tbl[i]) begin
            if (i > 0 && tbl[i].test != tbl[i-1].test) begin
                report_test(tbl[i-1].test);
            end
            @(posedge clk);
            #2;
            apply_entry(tbl[i]);
        end
        report_test(tbl[tbl.size()-1].test);
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Each entry gets at most 40 clock periods
    initial begin
        wait (built);
        #(tbl.size() * 40 * 20 + 2000);
        $display("watchdog expired before the stimulus table finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+common
common/afu_ctl_pkg.sv
src/afu_ctl/afu_csr_decode.sv
src/afu_ctl/afu_test_exec.sv
src/afu_ctl/afu_sreg_result.sv
src/afu_ctl_top.sv
dv/afu_ctl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AFU control block testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=afu_ctl_sim

verilator --binary --timing -Wno-fatal -f src.f --top-module afu_ctl_tb \
    -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi
echo "simulation passed"
exit 0
